// File: fpga_wrapper_pkg.sv
// Shared payload and status types; NIBBLES_PER_WORD must match the width of trng_word_t
package fpga_wrapper_pkg;

    // One debug character from the core's generic output register
    typedef logic [7:0] log_char_t;

    // Host-written entropy word and the nibble handed to the core
    typedef logic [31:0] trng_word_t;
    typedef logic [3:0]  trng_nibble_t;

    // Reload value of the entropy request throttle
    typedef logic [31:0] divisor_t;

    localparam int NIBBLES_PER_WORD = $bits(trng_word_t) / $bits(trng_nibble_t);

    // Flags of both side paths plus the free-running cycle counter
    typedef struct packed {
        logic        log_empty;
        logic        log_full;
        logic        itrng_empty;
        logic        itrng_full;
        logic [31:0] cycle_count;
    } wrapper_status_t;

endpackage

// File: fpga_wrapper_top.f
fpga_wrapper_pkg.sv
sync_fifo.sv
log_capture.sv
itrng_feeder.sv
status_regs.sv
fpga_wrapper_top.sv
tb_fpga_wrapper.sv

// File: fpga_wrapper_top.sv
// Side paths of the controller wrapper; depths must be powers of two, no handshakes on any port
`timescale 1ns/1ps

module fpga_wrapper_top import fpga_wrapper_pkg::*; #(
    parameter int LOG_DEPTH  = 16,
    parameter int TRNG_DEPTH = 8
) (
    input  logic            core_clk,
    input  logic            hwif_out,
    // Debug character log
    input  logic            char_wr,
    input  log_char_t       char_in,
    input  logic            log_rd,
    output log_char_t       next_char,
    output logic            char_valid,
    // Internal TRNG feed
    input  logic            itrng_wr,
    input  trng_word_t      itrng_word,
    input  logic            trng_flush,
    input  divisor_t        itrng_divisor,
    input  logic            etrng_req,
    output trng_nibble_t    itrng_data,
    output logic            itrng_valid,
    // Status
    input  logic            cptra_rst_b,
    output wrapper_status_t status
);

    logic log_empty;
    logic log_full;
    logic itrng_empty;
    logic itrng_full;

    log_capture #(
        .LOG_DEPTH (LOG_DEPTH)
    ) u_log_capture (
        .core_clk   (core_clk),
        .hwif_out   (hwif_out),
        .char_wr    (char_wr),
        .char_in    (char_in),
        .log_rd     (log_rd),
        .next_char  (next_char),
        .char_valid (char_valid),
        .log_empty  (log_empty),
        .log_full   (log_full)
    );

    itrng_feeder #(
        .TRNG_DEPTH (TRNG_DEPTH)
    ) u_itrng_feeder (
        .core_clk      (core_clk),
        .hwif_out      (hwif_out),
        .itrng_wr      (itrng_wr),
        .itrng_word    (itrng_word),
        .trng_flush    (trng_flush),
        .itrng_divisor (itrng_divisor),
        .etrng_req     (etrng_req),
        .itrng_data    (itrng_data),
        .itrng_valid   (itrng_valid),
        .itrng_empty   (itrng_empty),
        .itrng_full    (itrng_full)
    );

    status_regs u_status_regs (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .cptra_rst_b (cptra_rst_b),
        .log_empty   (log_empty),
        .log_full    (log_full),
        .itrng_empty (itrng_empty),
        .itrng_full  (itrng_full),
        .status      (status)
    );

endmodule

// File: itrng_feeder.sv
// Internal TRNG feed; word sampled one cycle after its strobe, one nibble per throttled grant
`timescale 1ns/1ps

module itrng_feeder import fpga_wrapper_pkg::*; #(
    parameter int TRNG_DEPTH = 8
) (
    input  logic         core_clk,
    input  logic         hwif_out,
    input  logic         itrng_wr,
    input  trng_word_t   itrng_word,
    input  logic         trng_flush,
    input  divisor_t     itrng_divisor,
    input  logic         etrng_req,
    output trng_nibble_t itrng_data,
    output logic         itrng_valid,
    output logic         itrng_empty,
    output logic         itrng_full
);

    localparam int IDX_W    = $clog2(NIBBLES_PER_WORD);
    localparam int NIBBLE_W = $bits(trng_nibble_t);

    logic             wr_d;
    divisor_t         throttle_cnt;
    logic             grant;
    logic [IDX_W-1:0] nibble_idx;
    trng_word_t       fifo_head;
    logic             fire;
    logic             fifo_pop;

    // Write data lands one cycle after the strobe
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_d <= 1'b0;
        end else begin
            wr_d <= itrng_wr;
        end
    end

    sync_fifo #(
        .payload_t (trng_word_t),
        .DEPTH     (TRNG_DEPTH)
    ) u_word_fifo (
        .core_clk (core_clk),
        .hwif_out (hwif_out),
        .flush    (trng_flush),
        .push     (wr_d),
        .wdata    (itrng_word),
        .pop      (fifo_pop),
        .rdata    (fifo_head),
        .empty    (itrng_empty),
        .full     (itrng_full)
    );

    // Throttle, grants land divisor+1 cycles apart while the request is held
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle_cnt <= '0;
            grant        <= 1'b0;
        end else if (throttle_cnt == '0) begin
            throttle_cnt <= itrng_divisor;
            grant        <= etrng_req;
        end else begin
            throttle_cnt <= throttle_cnt - 1'b1;
            grant        <= 1'b0;
        end
    end

    // A grant with nothing queued is lost
    assign fire     = grant & ~itrng_empty & ~trng_flush;
    assign fifo_pop = fire & (nibble_idx == IDX_W'(NIBBLES_PER_WORD - 1)); // Last nibble out

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            nibble_idx  <= '0;
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= fire;
            if (trng_flush) begin
                nibble_idx <= '0;
            end else if (fire) begin
                nibble_idx <= nibble_idx + 1'b1;
            end
        end
    end

    // Low nibble first
    always_ff @(posedge core_clk) begin
        if (fire) begin
            itrng_data <= fifo_head[nibble_idx*NIBBLE_W +: NIBBLE_W];
        end
    end

    // Grant cycle held the reloaded divisor; non-zero means no grant follows
    a_valid_single_pulse : assert property (
        @(posedge core_clk) disable iff (!hwif_out)
        (itrng_valid && $past(throttle_cnt) != '0) |=> !itrng_valid
    );

endmodule

// File: log_capture.sv
// Debug character log; a read strobe pops only if the FIFO held data the cycle before
`timescale 1ns/1ps

module log_capture import fpga_wrapper_pkg::*; #(
    parameter int LOG_DEPTH = 16
) (
    input  logic      core_clk,
    input  logic      hwif_out,
    input  logic      char_wr,
    input  log_char_t char_in,
    input  logic      log_rd,
    output log_char_t next_char,
    output logic      char_valid,
    output logic      log_empty,
    output logic      log_full
);

    logic valid_f;
    logic fifo_pop;

    assign char_valid = ~log_empty;

    // Host read acts on the valid it sampled
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            valid_f <= 1'b0;
        end else begin
            valid_f <= char_valid;
        end
    end

    // Also gated by the live flag, a back-to-back strobe may find the last entry gone
    assign fifo_pop = log_rd & valid_f & char_valid;

    sync_fifo #(
        .payload_t (log_char_t),
        .DEPTH     (LOG_DEPTH)
    ) u_log_fifo (
        .core_clk (core_clk),
        .hwif_out (hwif_out),
        .flush    (1'b0),      // Log is never flushed
        .push     (char_wr),
        .wdata    (char_in),
        .pop      (fifo_pop),
        .rdata    (next_char),
        .empty    (log_empty),
        .full     (log_full)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fpga_wrapper -f fpga_wrapper_top.f

./obj_dir/Vtb_fpga_wrapper > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

// File: status_regs.sv
// Status combiner; fields lag their inputs by one cycle and the counter holds zero in core reset
`timescale 1ns/1ps

module status_regs import fpga_wrapper_pkg::*; (
    input  logic            core_clk,
    input  logic            hwif_out,
    input  logic            cptra_rst_b,
    input  logic            log_empty,
    input  logic            log_full,
    input  logic            itrng_empty,
    input  logic            itrng_full,
    output wrapper_status_t status
);

    logic [31:0] count_next;

    // Free-running while the core is out of reset
    assign count_next = cptra_rst_b ? status.cycle_count + 32'd1 : '0;

    // Flags sampled alongside the counter so every field shares one cycle of lag
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            status.log_empty   <= 1'b1; // Both FIFOs empty out of reset
            status.log_full    <= 1'b0;
            status.itrng_empty <= 1'b1;
            status.itrng_full  <= 1'b0;
            status.cycle_count <= '0;
        end else begin
            status.log_empty   <= log_empty;
            status.log_full    <= log_full;
            status.itrng_empty <= itrng_empty;
            status.itrng_full  <= itrng_full;
            status.cycle_count <= count_next;
        end
    end

endmodule

// File: sync_fifo.sv
// First-word-fall-through FIFO; DEPTH must be a power of two, push while full is dropped
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic     core_clk,
    input  logic     hwif_out,
    input  logic     flush,
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,
    output payload_t rdata,
    output logic     empty,
    output logic     full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push_en;
    logic          pop_en;

    assign push_en = push & ~full & ~flush; // Flush wins over a same-cycle write
    assign pop_en  = pop & ~empty & ~flush;

    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(DEPTH));
    assign rdata = mem[rd_ptr];             // Head visible without a read cycle

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps naturally at DEPTH
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage only
    always_ff @(posedge core_clk) begin
        if (push_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Callers must gate their read strobe with the flags they see
    a_no_pop_when_empty : assert property (
        @(posedge core_clk) disable iff (!hwif_out) pop |-> !empty
    );

endmodule

// File: tb_fpga_wrapper.sv
// Assertion-based testbench; stimulus comes from a fixed-seed LFSR so every run is identical
`timescale 1ns/1ps

module tb_fpga_wrapper import fpga_wrapper_pkg::*; ();

    localparam int LOG_DEPTH  = 16;
    localparam int TRNG_DEPTH = 8;
    localparam int MAX_CYCLES = 3000; // Several times the length of all phases

    logic            core_clk, hwif_out, char_wr, log_rd, char_valid;
    logic            itrng_wr, trng_flush, etrng_req, itrng_valid, cptra_rst_b;
    log_char_t       char_in, next_char;
    trng_word_t      itrng_word;
    divisor_t        itrng_divisor;
    trng_nibble_t    itrng_data;
    wrapper_status_t status;

    logic [15:0]  lfsr;
    log_char_t    log_q[$];
    trng_nibble_t nib_q[$];
    log_char_t    exp_head;
    trng_nibble_t exp_nib;
    logic [31:0]  prev_count;
    logic         vf_m, wr_m, do_push, exp_log_valid, full_d, empty_d;
    logic         have_prev, spacing_on, trng_empty_d, trng_full_d, rst_b_d, count_armed;
    int           log_n, word_n, nib_pending, since, spacing_gap, div;
    int           pulse_total, nib_total, watchdog;

    fpga_wrapper_top #(.LOG_DEPTH(LOG_DEPTH), .TRNG_DEPTH(TRNG_DEPTH)) u_dut (.*);

    initial begin
        core_clk = 1'b0;
        forever #2 core_clk = ~core_clk;
    end

    initial begin
        watchdog = 0;
        while (watchdog < MAX_CYCLES) begin
            @(posedge core_clk);
            watchdog++;
        end
        $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $fatal(1);
    end

    // Fibonacci LFSR x^16+x^14+x^13+x^11 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic write_chars(input int n);
        int   sent;
        logic strobe;
        sent = 0;
        while (sent < n) begin
            @(posedge core_clk);
            strobe = (take_bits(1) != 0);
            char_wr <= strobe;
            char_in <= log_char_t'(take_bits(8));
            if (strobe) begin
                sent++;
            end
        end
        @(posedge core_clk);
        char_wr <= 1'b0;
    endtask

    task automatic read_log();
        while (log_q.size() != 0) begin
            @(posedge core_clk);
            log_rd <= (take_bits(1) != 0);
        end
        @(posedge core_clk);
        log_rd <= 1'b0;
    endtask

    // Word follows its strobe by one cycle
    task automatic push_word(input trng_word_t w);
        @(posedge core_clk);
        itrng_wr <= 1'b1;
        @(posedge core_clk);
        itrng_wr   <= 1'b0;
        itrng_word <= w;
        nib_total  += NIBBLES_PER_WORD;
    endtask

    task automatic wait_nibbles_out();
        repeat (2) @(posedge core_clk);
        while (nib_q.size() != 0) @(posedge core_clk);
        repeat (12) @(posedge core_clk); // No stray pulses after the last word
    endtask

    // Reference models; compared values change on the edge like the DUT outputs
    always @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            log_q.delete();
            nib_q.delete();
            vf_m          = 1'b0;
            wr_m          = 1'b0;
            pulse_total   = 0;
            exp_log_valid <= 1'b0;
            full_d        <= 1'b0;
            empty_d       <= 1'b1;
            trng_empty_d  <= 1'b1;
            trng_full_d   <= 1'b0;
            nib_pending   <= 0;
            have_prev     <= 1'b0;
            count_armed   <= 1'b0;
        end else begin
            log_n   = log_q.size();
            full_d  <= (log_n == LOG_DEPTH); // Status trails the FIFO by a cycle
            empty_d <= (log_n == 0);
            do_push = char_wr && (log_n < LOG_DEPTH);
            if (log_rd && vf_m && log_n != 0) begin
                void'(log_q.pop_front());
            end
            if (do_push) begin
                log_q.push_back(char_in);
            end
            vf_m          = (log_n != 0);
            exp_log_valid <= (log_q.size() != 0);
            exp_head      <= (log_q.size() != 0) ? log_q[0] : '0;
            if (itrng_valid && nib_q.size() != 0) begin
                void'(nib_q.pop_front());
                pulse_total++;
            end
            // A word leaves the FIFO one edge before its last nibble is seen
            word_n       = (nib_q.size() + NIBBLES_PER_WORD - 1) / NIBBLES_PER_WORD;
            trng_empty_d <= (word_n == 0);
            trng_full_d  <= (word_n == TRNG_DEPTH);
            if (trng_flush) begin
                nib_q.delete();
            end else if (wr_m && word_n < TRNG_DEPTH) begin
                for (int i = 0; i < NIBBLES_PER_WORD; i++) begin
                    nib_q.push_back(itrng_word[4*i +: 4]); // Low nibble first
                end
            end
            wr_m        = itrng_wr;
            nib_pending <= nib_q.size();
            exp_nib     <= (nib_q.size() != 0) ? nib_q[0] : '0;
            since       <= itrng_valid ? 1 : since + 1;
            have_prev   <= spacing_on && (itrng_valid || have_prev);
            count_armed <= 1'b1;
            rst_b_d     <= cptra_rst_b;
            prev_count  <= status.cycle_count;
        end
    end

    a_char_valid : assert property (@(posedge core_clk) disable iff (!hwif_out)
        char_valid == exp_log_valid)
        else report_mismatch("char_valid", $sampled(exp_log_valid), $sampled(char_valid));
    a_next_char : assert property (@(posedge core_clk) disable iff (!hwif_out)
        exp_log_valid |-> next_char == exp_head)
        else report_mismatch("next_char", $sampled(exp_head), $sampled(next_char));
    a_log_full : assert property (@(posedge core_clk) disable iff (!hwif_out)
        status.log_full == full_d)
        else report_mismatch("status.log_full", $sampled(full_d), $sampled(status.log_full));
    a_log_empty : assert property (@(posedge core_clk) disable iff (!hwif_out)
        status.log_empty == empty_d)
        else report_mismatch("status.log_empty", $sampled(empty_d), $sampled(status.log_empty));
    a_nib_queued : assert property (@(posedge core_clk) disable iff (!hwif_out)
        itrng_valid |-> nib_pending != 0)
        else report_error("itrng_valid pulsed while no entropy nibble was queued");
    a_nib_data : assert property (@(posedge core_clk) disable iff (!hwif_out)
        (itrng_valid && nib_pending != 0) |-> itrng_data == exp_nib)
        else report_mismatch("itrng_data", $sampled(exp_nib), $sampled(itrng_data));
    a_spacing : assert property (@(posedge core_clk) disable iff (!hwif_out)
        (itrng_valid && have_prev) |-> since == spacing_gap)
        else report_mismatch("itrng_valid spacing", $sampled(spacing_gap), $sampled(since));
    a_trng_empty : assert property (@(posedge core_clk) disable iff (!hwif_out)
        status.itrng_empty == trng_empty_d)
        else report_mismatch("status.itrng_empty", $sampled(trng_empty_d),
                             $sampled(status.itrng_empty));
    a_trng_full : assert property (@(posedge core_clk) disable iff (!hwif_out)
        status.itrng_full == trng_full_d)
        else report_mismatch("status.itrng_full", $sampled(trng_full_d),
                             $sampled(status.itrng_full));
    a_count_inc : assert property (@(posedge core_clk) disable iff (!hwif_out)
        (count_armed && rst_b_d) |-> status.cycle_count == prev_count + 32'd1)
        else report_mismatch("status.cycle_count", $sampled(prev_count) + 32'd1,
                             $sampled(status.cycle_count));
    a_count_zero : assert property (@(posedge core_clk) disable iff (!hwif_out)
        (count_armed && !rst_b_d) |-> status.cycle_count == '0)
        else report_mismatch("status.cycle_count", 0, $sampled(status.cycle_count));

    initial begin
        lfsr          = 16'd25642;
        hwif_out      = 1'b0;
        char_wr       = 1'b0;
        char_in       = '0;
        log_rd        = 1'b0;
        itrng_wr      = 1'b0;
        itrng_word    = '0;
        trng_flush    = 1'b0;
        itrng_divisor = '0;
        etrng_req     = 1'b0;
        cptra_rst_b   = 1'b0;
        spacing_on    = 1'b0;
        spacing_gap   = 1;
        nib_total     = 0;
        repeat (3) @(posedge core_clk);
        hwif_out    <= 1'b1;
        cptra_rst_b <= 1'b1;

        write_chars(12);            // Log order
        read_log();
        write_chars(LOG_DEPTH + 3); // Last three writes hit a full FIFO
        read_log();

        // Full-rate nibble order
        @(posedge core_clk);
        etrng_req <= 1'b1;
        repeat (4) push_word(take_bits(32));
        wait_nibbles_out();

        // Throttled spacing with divisor 1 to 5
        div = take_bits(3) % 5 + 1;
        @(posedge core_clk);
        itrng_divisor <= div;
        spacing_gap   <= div + 1;
        spacing_on    <= 1'b1;
        repeat (3) push_word(take_bits(32));
        wait_nibbles_out();
        @(posedge core_clk);
        spacing_on <= 1'b0;
        etrng_req  <= 1'b0;
        repeat (8) @(posedge core_clk);

        // Overfill and flush the word FIFO while requests are held off
        repeat (TRNG_DEPTH + 1) push_word(take_bits(32));
        nib_total -= (TRNG_DEPTH + 1) * NIBBLES_PER_WORD;
        while (!status.itrng_full) @(posedge core_clk);
        @(posedge core_clk);
        trng_flush <= 1'b1;
        @(posedge core_clk);
        trng_flush <= 1'b0;
        etrng_req  <= 1'b1; // Requests against the emptied FIFO
        repeat (30) @(posedge core_clk);

        // Core reset clears the cycle counter
        cptra_rst_b <= 1'b0;
        repeat (3) @(posedge core_clk);
        cptra_rst_b <= 1'b1;
        repeat (10) @(posedge core_clk);

        if (pulse_total != nib_total) begin
            report_mismatch("nibbles delivered", nib_total, pulse_total);
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule
